//--- common/spart_bus_pkg.sv
package spart_bus_pkg;

	//////////////////////////////
	// Bus types
	//////////////////////////////

	// One data byte on the SPART bus
	typedef logic [7:0] bus_byte_t;

	// SPART register select
	typedef logic [1:0] io_addr_t;

	// Baud generator divisor, written as two bytes
	typedef logic [15:0] divisor_t;

	//////////////////////////////
	// Register map
	//////////////////////////////

	// Transmit buffer on write, receive buffer on read
	localparam io_addr_t ADDR_DATA   = 2'd0;
	localparam io_addr_t ADDR_DIV_LO = 2'd2;
	localparam io_addr_t ADDR_DIV_HI = 2'd3;

	// Divisor table, indexed by br_cfg 0 to 3
	localparam divisor_t DIV_4800  = 16'h12c0;
	localparam divisor_t DIV_9600  = 16'h2580;
	localparam divisor_t DIV_19200 = 16'h4b00;
	localparam divisor_t DIV_38400 = 16'h9600;

	//////////////////////////////
	// Console characters
	//////////////////////////////

	localparam bus_byte_t ASCII_CR    = 8'h0d;
	localparam bus_byte_t ASCII_SPACE = 8'h20;
	// Step the pointer down and up
	localparam bus_byte_t ASCII_DEC   = 8'h31;
	localparam bus_byte_t ASCII_INC   = 8'h32;

	// Bases for hex digit conversion, upper case letters
	localparam bus_byte_t ASCII_ZERO    = 8'h30;
	localparam bus_byte_t ASCII_UPPER_A = 8'h41;

endpackage

//--- common/debug_pkg.sv
package debug_pkg;

	//////////////////////////////
	// Trace table
	//////////////////////////////

	// One captured trace value
	typedef logic [31:0] trace_word_t;

	// Entry index, also used as the dump pointer
	typedef logic [2:0] entry_idx_t;

	// Selects one hex digit of a trace word
	typedef logic [2:0] nibble_idx_t;

	localparam int NUM_ENTRIES = 6;

	// Hex digits per trace word
	localparam int HEX_DIGITS = 8;

	//////////////////////////////
	// Console FSM
	//////////////////////////////

	typedef enum logic [3:0] {
		INIT_LO,
		INIT_HI,
		CMD_WAIT,
		LIST_INDEX,
		LIST_DIGIT,
		LIST_SPACE,
		ECHO_PTR,
		ECHO_SPACE,
		HEX_DIGIT,
		HEX_SPACE
	} console_state_t;

endpackage

//--- src/trace_capture.sv
`timescale 1ns/10ps

module trace_capture (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   trace_valid,
	input  debug_pkg::entry_idx_t  trace_idx,
	input  debug_pkg::trace_word_t trace_data,
	input  debug_pkg::entry_idx_t  rd_idx,
	output debug_pkg::trace_word_t rd_data
);

	debug_pkg::trace_word_t entries [debug_pkg::NUM_ENTRIES];

	logic trace_hit;

	// Indices past the table are dropped
	assign trace_hit = trace_valid &&
		(trace_idx < debug_pkg::entry_idx_t'(debug_pkg::NUM_ENTRIES));

	//////////////////////////////
	// Write port
	//////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < debug_pkg::NUM_ENTRIES; i++) begin
				entries[i] <= '0;
			end
		end else if (trace_hit) begin
			entries[trace_idx] <= trace_data;
		end
	end

	//////////////////////////////
	// Read port
	//////////////////////////////

	// Unmatched index falls through as zero
	always_comb begin
		rd_data = '0;
		for (int i = 0; i < debug_pkg::NUM_ENTRIES; i++) begin
			if (rd_idx == debug_pkg::entry_idx_t'(i)) begin
				rd_data = entries[i];
			end
		end
	end

endmodule

//--- console/dump_cursor.sv
`timescale 1ns/10ps

module dump_cursor (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      ptr_clear,
	input  logic                      ptr_inc,
	input  logic                      ptr_dec,
	input  logic                      nib_load,
	input  logic                      nib_clear,
	input  logic                      nib_dec,
	input  debug_pkg::trace_word_t    rd_data,
	output debug_pkg::entry_idx_t     rd_idx,
	output debug_pkg::entry_idx_t     ptr,
	output spart_bus_pkg::bus_byte_t  ptr_ascii,
	output spart_bus_pkg::bus_byte_t  digit_ascii,
	output logic                      nib_last
);

	debug_pkg::nibble_idx_t nib;
	logic [3:0]             digit;

	// Upper case hex digit to its character
	function automatic spart_bus_pkg::bus_byte_t hex_to_ascii(input logic [3:0] hex);
		spart_bus_pkg::bus_byte_t code;
		if (hex < 4'd10) begin
			code = spart_bus_pkg::ASCII_ZERO + {4'h0, hex};
		end else begin
			code = spart_bus_pkg::ASCII_UPPER_A + {4'h0, hex - 4'd10};
		end
		return code;
	endfunction

	//////////////////////////////
	// Pointer and nibble counter
	//////////////////////////////

	// Pointer wraps modulo eight
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (ptr_clear) begin
			ptr <= '0;
		end else if (ptr_inc) begin
			ptr <= ptr + 3'd1;
		end else if (ptr_dec) begin
			ptr <= ptr - 3'd1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			nib <= '0;
		end else if (nib_load) begin
			nib <= debug_pkg::nibble_idx_t'(debug_pkg::HEX_DIGITS - 1);
		end else if (nib_clear) begin
			nib <= '0;
		end else if (nib_dec) begin
			nib <= nib - 3'd1;
		end
	end

	//////////////////////////////
	// Character conversion
	//////////////////////////////

	assign rd_idx      = ptr;
	assign digit       = rd_data[{nib, 2'b00} +: 4];
	assign digit_ascii = hex_to_ascii(digit);
	assign ptr_ascii   = hex_to_ascii({1'b0, ptr});
	assign nib_last    = (nib == '0);

endmodule

//--- console/console_fsm.sv
`timescale 1ns/10ps

module console_fsm (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [1:0]                br_cfg,
	input  logic                      rda,
	input  logic                      tbr,
	input  spart_bus_pkg::bus_byte_t  db_in,
	input  debug_pkg::entry_idx_t     ptr,
	input  spart_bus_pkg::bus_byte_t  ptr_ascii,
	input  spart_bus_pkg::bus_byte_t  digit_ascii,
	input  logic                      nib_last,
	output logic                      iocs,
	output logic                      iorw,
	output spart_bus_pkg::io_addr_t   ioaddr,
	output spart_bus_pkg::bus_byte_t  db_out,
	output logic                      db_oe,
	output logic                      ptr_clear,
	output logic                      ptr_inc,
	output logic                      ptr_dec,
	output logic                      nib_load,
	output logic                      nib_clear,
	output logic                      nib_dec
);

	debug_pkg::console_state_t state;
	debug_pkg::console_state_t state_next;

	// Low after reset until the first clock edge
	logic started;

	spart_bus_pkg::divisor_t divisor;

	// Access request for this cycle
	logic                     wr_en;
	logic                     rd_en;
	spart_bus_pkg::io_addr_t  wr_addr;
	spart_bus_pkg::bus_byte_t wr_byte;

	function automatic spart_bus_pkg::divisor_t div_lookup(input logic [1:0] cfg);
		spart_bus_pkg::divisor_t div;
		case (cfg)
			2'd0:    div = spart_bus_pkg::DIV_4800;
			2'd1:    div = spart_bus_pkg::DIV_9600;
			2'd2:    div = spart_bus_pkg::DIV_19200;
			default: div = spart_bus_pkg::DIV_38400;
		endcase
		return div;
	endfunction

	assign divisor = div_lookup(br_cfg);

	//////////////////////////////
	// State registers
	//////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= debug_pkg::INIT_LO;
			started <= 1'b0;
		end else begin
			state   <= state_next;
			started <= 1'b1;
		end
	end

	//////////////////////////////
	// Next state and bus requests
	//////////////////////////////

	always_comb begin
		state_next = state;
		wr_en      = 1'b0;
		rd_en      = 1'b0;
		wr_addr    = spart_bus_pkg::ADDR_DATA;
		wr_byte    = '0;
		ptr_clear  = 1'b0;
		ptr_inc    = 1'b0;
		ptr_dec    = 1'b0;
		nib_load   = 1'b0;
		nib_clear  = 1'b0;
		nib_dec    = 1'b0;

		case (state)
			debug_pkg::INIT_LO: begin
				if (started) begin
					wr_en      = 1'b1;
					wr_addr    = spart_bus_pkg::ADDR_DIV_LO;
					wr_byte    = divisor[7:0];
					state_next = debug_pkg::INIT_HI;
				end
			end
			debug_pkg::INIT_HI: begin
				wr_en      = 1'b1;
				wr_addr    = spart_bus_pkg::ADDR_DIV_HI;
				wr_byte    = divisor[15:8];
				state_next = debug_pkg::CMD_WAIT;
			end
			// Receive byte is decoded in the cycle it is read
			debug_pkg::CMD_WAIT: begin
				if (rda) begin
					rd_en = 1'b1;
					case (db_in)
						spart_bus_pkg::ASCII_CR: begin
							ptr_clear  = 1'b1;
							nib_clear  = 1'b1;
							state_next = debug_pkg::LIST_INDEX;
						end
						spart_bus_pkg::ASCII_SPACE: begin
							ptr_clear  = 1'b1;
							nib_load   = 1'b1;
							state_next = debug_pkg::HEX_DIGIT;
						end
						spart_bus_pkg::ASCII_DEC: begin
							ptr_dec    = 1'b1;
							state_next = debug_pkg::ECHO_PTR;
						end
						spart_bus_pkg::ASCII_INC: begin
							ptr_inc    = 1'b1;
							state_next = debug_pkg::ECHO_PTR;
						end
						default: state_next = debug_pkg::CMD_WAIT;
					endcase
				end
			end
			// Short list: index, low digit, space per entry
			debug_pkg::LIST_INDEX: begin
				if (tbr) begin
					wr_en      = 1'b1;
					wr_byte    = ptr_ascii;
					state_next = debug_pkg::LIST_DIGIT;
				end
			end
			debug_pkg::LIST_DIGIT: begin
				if (tbr) begin
					wr_en      = 1'b1;
					wr_byte    = digit_ascii;
					ptr_inc    = 1'b1;
					state_next = debug_pkg::LIST_SPACE;
				end
			end
			debug_pkg::LIST_SPACE: begin
				if (tbr) begin
					wr_en   = 1'b1;
					wr_byte = spart_bus_pkg::ASCII_SPACE;
					if (ptr == debug_pkg::entry_idx_t'(debug_pkg::NUM_ENTRIES)) begin
						state_next = debug_pkg::CMD_WAIT;
					end else begin
						state_next = debug_pkg::LIST_INDEX;
					end
				end
			end
			// Pointer echo after a step
			debug_pkg::ECHO_PTR: begin
				if (tbr) begin
					wr_en      = 1'b1;
					wr_byte    = ptr_ascii;
					state_next = debug_pkg::ECHO_SPACE;
				end
			end
			debug_pkg::ECHO_SPACE: begin
				if (tbr) begin
					wr_en      = 1'b1;
					wr_byte    = spart_bus_pkg::ASCII_SPACE;
					state_next = debug_pkg::CMD_WAIT;
				end
			end
			// Full dump, most significant digit first
			debug_pkg::HEX_DIGIT: begin
				if (tbr) begin
					wr_en   = 1'b1;
					wr_byte = digit_ascii;
					if (nib_last) begin
						state_next = debug_pkg::HEX_SPACE;
					end else begin
						nib_dec = 1'b1;
					end
				end
			end
			debug_pkg::HEX_SPACE: begin
				if (tbr) begin
					wr_en   = 1'b1;
					wr_byte = spart_bus_pkg::ASCII_SPACE;
					if (ptr == debug_pkg::entry_idx_t'(debug_pkg::NUM_ENTRIES - 1)) begin
						state_next = debug_pkg::CMD_WAIT;
					end else begin
						ptr_inc    = 1'b1;
						nib_load   = 1'b1;
						state_next = debug_pkg::HEX_DIGIT;
					end
				end
			end
			default: state_next = debug_pkg::CMD_WAIT;
		endcase
	end

	// Bus pins from the request
	assign iocs   = wr_en | rd_en;
	assign iorw   = ~wr_en;
	assign db_oe  = wr_en;
	assign ioaddr = wr_addr;
	assign db_out = wr_byte;

endmodule

//--- src/spart_driver.sv
`timescale 1ns/10ps

module spart_driver (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [1:0]                br_cfg,
	input  logic                      rda,
	input  logic                      tbr,
	input  spart_bus_pkg::bus_byte_t  db_in,
	output logic                      iocs,
	output logic                      iorw,
	output spart_bus_pkg::io_addr_t   ioaddr,
	output spart_bus_pkg::bus_byte_t  db_out,
	output logic                      db_oe,
	input  logic                      trace_valid,
	input  debug_pkg::entry_idx_t     trace_idx,
	input  debug_pkg::trace_word_t    trace_data
);

	// Cursor control from the console
	logic ptr_clear;
	logic ptr_inc;
	logic ptr_dec;
	logic nib_load;
	logic nib_clear;
	logic nib_dec;

	// Cursor state and converted characters
	debug_pkg::entry_idx_t    ptr;
	spart_bus_pkg::bus_byte_t ptr_ascii;
	spart_bus_pkg::bus_byte_t digit_ascii;
	logic                     nib_last;

	// Table read path
	debug_pkg::entry_idx_t  rd_idx;
	debug_pkg::trace_word_t rd_data;

	trace_capture i_trace_capture (
		.clk         (clk),
		.rst         (rst),
		.trace_valid (trace_valid),
		.trace_idx   (trace_idx),
		.trace_data  (trace_data),
		.rd_idx      (rd_idx),
		.rd_data     (rd_data)
	);

	dump_cursor i_dump_cursor (
		.clk         (clk),
		.rst         (rst),
		.ptr_clear   (ptr_clear),
		.ptr_inc     (ptr_inc),
		.ptr_dec     (ptr_dec),
		.nib_load    (nib_load),
		.nib_clear   (nib_clear),
		.nib_dec     (nib_dec),
		.rd_data     (rd_data),
		.rd_idx      (rd_idx),
		.ptr         (ptr),
		.ptr_ascii   (ptr_ascii),
		.digit_ascii (digit_ascii),
		.nib_last    (nib_last)
	);

	console_fsm i_console_fsm (
		.clk         (clk),
		.rst         (rst),
		.br_cfg      (br_cfg),
		.rda         (rda),
		.tbr         (tbr),
		.db_in       (db_in),
		.ptr         (ptr),
		.ptr_ascii   (ptr_ascii),
		.digit_ascii (digit_ascii),
		.nib_last    (nib_last),
		.iocs        (iocs),
		.iorw        (iorw),
		.ioaddr      (ioaddr),
		.db_out      (db_out),
		.db_oe       (db_oe),
		.ptr_clear   (ptr_clear),
		.ptr_inc     (ptr_inc),
		.ptr_dec     (ptr_dec),
		.nib_load    (nib_load),
		.nib_clear   (nib_clear),
		.nib_dec     (nib_dec)
	);

endmodule

//--- verification/spart_driver_chk.sv
`timescale 1ns/10ps

module spart_driver_chk (
	input logic                    clk,
	input logic                    rst,
	input logic                    rda,
	input logic                    tbr,
	input logic                    iocs,
	input logic                    iorw,
	input spart_bus_pkg::io_addr_t ioaddr,
	input logic                    db_oe
);

	// Bus idle while reset is held
	a_rst_idle: assert property (@(posedge clk)
		rst |-> (!iocs && !db_oe))
		else $error("bus access while reset is high");

	// Transmit buffer written only when empty
	a_tx_tbr: assert property (@(posedge clk) disable iff (rst)
		(iocs && !iorw && ioaddr == spart_bus_pkg::ADDR_DATA) |-> tbr)
		else $error("transmit write while tbr is low");

	a_rd_rda: assert property (@(posedge clk) disable iff (rst)
		(iocs && iorw) |-> rda)
		else $error("receive read while rda is low");

endmodule

bind console_fsm spart_driver_chk i_spart_driver_chk (
	.clk    (clk),
	.rst    (rst),
	.rda    (rda),
	.tbr    (tbr),
	.iocs   (iocs),
	.iorw   (iorw),
	.ioaddr (ioaddr),
	.db_oe  (db_oe)
);

//--- verification/tb_spart_driver.sv
`timescale 1ns/10ps

module tb_spart_driver;

	localparam int NUM_ROWS     = 11;
	localparam int INIT_TIMEOUT = 50;
	localparam int READ_TIMEOUT = 100;
	localparam int DUMP_TIMEOUT = 2000;
	localparam int QUIET_CYCLES = 40;

	//////////////////////////////
	// Command table
	//////////////////////////////

	localparam spart_bus_pkg::bus_byte_t ROW_CMD [NUM_ROWS] = '{
		spart_bus_pkg::ASCII_CR, spart_bus_pkg::ASCII_SPACE,
		spart_bus_pkg::ASCII_INC, spart_bus_pkg::ASCII_INC, spart_bus_pkg::ASCII_INC,
		spart_bus_pkg::ASCII_DEC, spart_bus_pkg::ASCII_DEC,
		8'h41,
		spart_bus_pkg::ASCII_CR, spart_bus_pkg::ASCII_SPACE, spart_bus_pkg::ASCII_DEC
	};
	// Output bytes expected per row
	localparam int ROW_COUNT [NUM_ROWS] = '{18, 54, 2, 2, 2, 2, 2, 0, 18, 54, 2};
	// Trace action before the command with 1 filling entries 0 to 5 and 2 writing 6 and 7
	localparam int ROW_PRE [NUM_ROWS] = '{1, 0, 0, 0, 0, 0, 0, 2, 0, 1, 0};
	// Random tbr low cycles during the row
	localparam bit ROW_STALL [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1};

	logic                       clk = 1'b0;
	logic                       rst;
	logic [1:0]                 br_cfg;
	logic                       rda;
	logic                       tbr = 1'b1;
	spart_bus_pkg::bus_byte_t   db_in;
	logic                       iocs;
	logic                       iorw;
	spart_bus_pkg::io_addr_t    ioaddr;
	spart_bus_pkg::bus_byte_t   db_out;
	logic                       db_oe;
	logic                       trace_valid;
	debug_pkg::entry_idx_t      trace_idx;
	debug_pkg::trace_word_t     trace_data;

	// Bus log from the SPART model
	spart_bus_pkg::io_addr_t    acc_addr_q [$];
	spart_bus_pkg::bus_byte_t   acc_byte_q [$];
	logic                       acc_rd_q [$];
	spart_bus_pkg::bus_byte_t   tx_q [$];

	// Reference model state
	debug_pkg::trace_word_t     model_entry [6];
	debug_pkg::entry_idx_t      model_ptr;
	spart_bus_pkg::bus_byte_t   exp_q [$];

	bit tbr_random = 1'b0;
	int test_errors = 0;
	int total_errors = 0;
	int test_num = 0;
	int pass_count = 0;
	int fail_count = 0;

	spart_driver i_dut (
		.clk         (clk),
		.rst         (rst),
		.br_cfg      (br_cfg),
		.rda         (rda),
		.tbr         (tbr),
		.db_in       (db_in),
		.iocs        (iocs),
		.iorw        (iorw),
		.ioaddr      (ioaddr),
		.db_out      (db_out),
		.db_oe       (db_oe),
		.trace_valid (trace_valid),
		.trace_idx   (trace_idx),
		.trace_data  (trace_data)
	);

	always #4 clk = ~clk;

	//////////////////////////////
	// SPART model
	//////////////////////////////

	always @(posedge clk) begin
		if (tbr_random) begin
			tbr <= ($urandom % 32'd4) != 32'd0;
		end else begin
			tbr <= 1'b1;
		end
	end

	// Accesses logged mid cycle, where the bus is stable
	always @(negedge clk) begin
		// Data bus driven exactly in write cycles
		check_bit("db_oe", db_oe, iocs && !iorw);
		if (!rst && iocs) begin
			acc_addr_q.push_back(ioaddr);
			acc_byte_q.push_back(db_out);
			acc_rd_q.push_back(iorw);
			if (!iorw && ioaddr == spart_bus_pkg::ADDR_DATA) begin
				tx_q.push_back(db_out);
			end
		end
	end

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_byte(input string name, input spart_bus_pkg::bus_byte_t got,
			input spart_bus_pkg::bus_byte_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_addr(input string name, input spart_bus_pkg::io_addr_t got,
			input spart_bus_pkg::io_addr_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_divisor(input string name, input spart_bus_pkg::divisor_t got,
			input spart_bus_pkg::divisor_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		test_num++;
		if (test_errors == 0) begin
			pass_count++;
			$display("test %0d %s: PASS", test_num, name);
		end else begin
			fail_count++;
			$display("test %0d %s: FAIL with %0d errors", test_num, name, test_errors);
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic spart_bus_pkg::divisor_t expected_divisor(input logic [1:0] cfg);
		spart_bus_pkg::divisor_t div;
		case (cfg)
			2'd0:    div = 16'h12c0;
			2'd1:    div = 16'h2580;
			2'd2:    div = 16'h4b00;
			default: div = 16'h9600;
		endcase
		return div;
	endfunction

	// Upper case letters count from 'A' minus ten, which is 37 hex
	function automatic spart_bus_pkg::bus_byte_t hex_char(input logic [3:0] n);
		return (n < 4'd10) ? 8'h30 + {4'h0, n} : 8'h37 + {4'h0, n};
	endfunction

	task automatic predict(input spart_bus_pkg::bus_byte_t cmd);
		exp_q.delete();
		if (cmd == spart_bus_pkg::ASCII_CR) begin
			for (int e = 0; e < 6; e++) begin
				exp_q.push_back(hex_char(4'(e)));
				exp_q.push_back(hex_char(model_entry[e][3:0]));
				exp_q.push_back(spart_bus_pkg::ASCII_SPACE);
			end
			model_ptr = 3'd6;
		end else if (cmd == spart_bus_pkg::ASCII_SPACE) begin
			for (int e = 0; e < 6; e++) begin
				for (int d = 7; d >= 0; d--) begin
					exp_q.push_back(hex_char(model_entry[e][d*4 +: 4]));
				end
				exp_q.push_back(spart_bus_pkg::ASCII_SPACE);
			end
			model_ptr = 3'd5;
		end else if (cmd == spart_bus_pkg::ASCII_INC || cmd == spart_bus_pkg::ASCII_DEC) begin
			if (cmd == spart_bus_pkg::ASCII_INC) begin
				model_ptr = model_ptr + 3'd1;
			end else begin
				model_ptr = model_ptr - 3'd1;
			end
			exp_q.push_back(hex_char({1'b0, model_ptr}));
			exp_q.push_back(spart_bus_pkg::ASCII_SPACE);
		end
	endtask

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	task automatic write_trace(input debug_pkg::entry_idx_t idx,
			input debug_pkg::trace_word_t data);
		@(posedge clk);
		trace_valid <= 1'b1;
		trace_idx   <= idx;
		trace_data  <= data;
		@(posedge clk);
		trace_valid <= 1'b0;
		// Indices past the table are dropped
		if (int'(idx) < 6) begin
			model_entry[idx] = data;
		end
	endtask

	// Holds rda until the DUT reads the byte
	task automatic send_command(input spart_bus_pkg::bus_byte_t cmd, output bit ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		@(posedge clk);
		rda   <= 1'b1;
		db_in <= cmd;
		while (!ok && cycles < READ_TIMEOUT) begin
			@(negedge clk);
			if (iocs && iorw) begin
				ok = 1'b1;
				check_addr("ioaddr", ioaddr, spart_bus_pkg::ADDR_DATA);
			end
			cycles++;
		end
		@(posedge clk);
		rda <= 1'b0;
	endtask

	task automatic run_divisor_test(input logic [1:0] cfg);
		int base;
		int cycles;
		@(posedge clk);
		rst    <= 1'b1;
		br_cfg <= cfg;
		repeat (16) @(posedge clk);
		base = acc_addr_q.size();
		rst <= 1'b0;
		for (int e = 0; e < 6; e++) begin
			model_entry[e] = '0;
		end
		model_ptr = '0;
		cycles = 0;
		while (acc_addr_q.size() < base + 2 && cycles < INIT_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (acc_addr_q.size() < base + 2) begin
			$display("Divisor writes did not appear after reset");
			test_errors++;
		end else begin
			if (acc_rd_q[base] || acc_rd_q[base+1]) begin
				$display("A divisor access was a read instead of a write");
				test_errors++;
			end
			check_addr("ioaddr", acc_addr_q[base], spart_bus_pkg::ADDR_DIV_LO);
			check_addr("ioaddr", acc_addr_q[base+1], spart_bus_pkg::ADDR_DIV_HI);
			check_divisor("divisor", {acc_byte_q[base+1], acc_byte_q[base]},
				expected_divisor(cfg));
		end
		finish_test($sformatf("divisor br_cfg=%0d", cfg));
	endtask

	task automatic run_row(input int r);
		int base;
		int cycles;
		bit ok;
		if (ROW_PRE[r] == 1) begin
			for (int e = 0; e < 6; e++) begin
				write_trace(3'(e), $urandom);
			end
		end else if (ROW_PRE[r] == 2) begin
			write_trace(3'd6, $urandom);
			write_trace(3'd7, $urandom);
		end
		tbr_random = ROW_STALL[r];
		predict(ROW_CMD[r]);
		base = tx_q.size();
		send_command(ROW_CMD[r], ok);
		if (!ok) begin
			$display("Command byte 0x%h was never read by the DUT", ROW_CMD[r]);
			test_errors++;
		end
		cycles = 0;
		while (tx_q.size() < base + ROW_COUNT[r] && cycles < DUMP_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		// Quiet window catches extra bytes
		cycles = 0;
		while (cycles < QUIET_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (tx_q.size() != base + ROW_COUNT[r]) begin
			$display("DUT wrote %0d bytes where %0d were expected",
				tx_q.size() - base, ROW_COUNT[r]);
			test_errors++;
		end else begin
			for (int i = 0; i < ROW_COUNT[r] && i < exp_q.size(); i++) begin
				check_byte($sformatf("db_out byte %0d", i), tx_q[base+i], exp_q[i]);
			end
		end
		finish_test($sformatf("command 0x%h stall=%0d", ROW_CMD[r], ROW_STALL[r]));
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		void'($urandom(32'hd6d));
		rst         <= 1'b1;
		br_cfg      <= 2'd0;
		rda         <= 1'b0;
		db_in       <= '0;
		trace_valid <= 1'b0;
		trace_idx   <= '0;
		trace_data  <= '0;
		for (int cfg = 0; cfg < 4; cfg++) begin
			run_divisor_test(2'(cfg));
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		tbr_random = 1'b0;
		$display("summary: %0d run, %0d passed, %0d failed",
			test_num, pass_count, fail_count);
		if (total_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
common/spart_bus_pkg.sv
common/debug_pkg.sv
src/trace_capture.sv
console/dump_cursor.sv
console/console_fsm.sv
src/spart_driver.sv
verification/spart_driver_chk.sv
verification/tb_spart_driver.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

ROOT=$(cd "$(dirname "$0")" && pwd)
BUILD_DIR=obj_dir
LOG_FILE=sim.log

cd "$ROOT" || exit 1

verilator --binary --timing --assert -Mdir "$BUILD_DIR" \
	--top-module tb_spart_driver -f verilog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_spart_driver" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

# The testbench result is taken from the log
if grep -q "tests failed" "$LOG_FILE"; then
	exit 1
fi
exit 0
